/* src/wb_consts.svh */
// Widths, reset PC, functional unit bits, micro-op codes and trap causes
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

`define WB_XLEN           32            // Data and PC width
`define WB_PC_RESET       32'h8000_0000 // PC after reset

// One-hot functional unit bit positions
`define WB_FU_ALU         0
`define WB_FU_MUL         1
`define WB_FU_LSU         2
`define WB_FU_CFU         3
`define WB_FU_CSR         4

// CFU micro-op codes
`define WB_CFU_TAKEN      5'd1          // Predicted taken branch
`define WB_CFU_JALI       5'd2          // Immediate jump and link
`define WB_CFU_NOT_TAKEN  5'd3          // Mispredicted branch
`define WB_CFU_JALR       5'd4          // Register jump and link
`define WB_CFU_EBREAK     5'd5
`define WB_CFU_ECALL      5'd6
`define WB_CFU_MRET       5'd7

// CSR micro-op bit positions
`define WB_CSR_READ       4
`define WB_CSR_WRITE      3
`define WB_CSR_SET        2
`define WB_CSR_CLEAR      1

// LSU micro-op bit positions and size codes in bits 2 to 1
`define WB_LSU_LOAD       3
`define WB_LSU_STORE      4
`define WB_LSU_SIGNED     0
`define WB_LSU_BYTE       2'b01
`define WB_LSU_HALF       2'b10
`define WB_LSU_WORD       2'b11

// Trap causes
`define WB_TRAP_LDACCESS  6'd5
`define WB_TRAP_STACCESS  6'd7
`define WB_TRAP_BREAKPT   6'd3
`define WB_TRAP_ECALLM    6'd11

`endif

/* src/wb_pkg.sv */
// Package with the packed struct types of the writeback stage
`default_nettype none

`include "wb_consts.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0] wb_word_t; // One machine word

    // Instruction held in the writeback stage
    typedef struct packed {
        logic [4:0]  rd;     // Destination register
        wb_word_t    opr_a;  // Result, target or strobes
        wb_word_t    opr_b;  // Address or CSR number
        logic [4:0]  uop;    // Micro-op
        logic [4:0]  fu;     // One-hot functional unit
        logic        trap;   // Trap raised upstream
        logic [1:0]  size;   // Length in halfwords
        logic [31:0] instr;  // Instruction word
    } wb_instr_t;

    // GPR write port, also the forwarding port
    typedef struct packed {
        logic       wen;
        logic [4:0] rd;
        wb_word_t   wdata;
    } wb_gpr_write_t;

    typedef struct packed {
        logic        en;     // Access strobe
        logic        wr;     // Plain write
        logic        wr_set; // Bit set
        logic        wr_clr; // Bit clear
        logic [11:0] addr;
        wb_word_t    wdata;
    } wb_csr_req_t;

    typedef struct packed {
        logic     req;
        wb_word_t target;
    } wb_cf_req_t;

    typedef struct packed {
        logic       cpu;     // Synchronous trap taken
        logic [5:0] cause;
        wb_word_t   pc;
    } wb_trap_t;

    typedef struct packed {
        logic     recv;
        logic     error;
        wb_word_t rdata;
    } wb_dmem_rsp_t;

    typedef struct packed {
        logic        valid;
        wb_word_t    pc;
        logic [31:0] instr;
    } wb_trace_t;

endpackage

`default_nettype wire

/* src/wb_control_flow.sv */
// PC register, control flow target, request tracking and trap cause
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module wb_control_flow import wb_pkg::*; (
    input  wire            g_clk,
    input  wire            g_resetn,
    input  wire            s4_valid,
    input  wire wb_instr_t s4_instr,
    input  wire            progress,      // Instruction retires this cycle
    input  wire            cf_ack,
    input  wire wb_word_t  csr_mepc,
    input  wire wb_word_t  csr_mtvec,
    input  wire            lsu_trap,      // Data bus error
    input  wire            lsu_store_err, // Bus error was on a store
    output wb_cf_req_t     cf,
    output wb_trap_t       trap,
    output logic           exec_mret,
    output logic           cfu_busy,
    output wb_word_t       pc,
    output wb_word_t       next_pc,
    output logic           cf_done
);

    logic fu_cfu;
    logic pred_correct; // PC already redirected upstream
    logic tgt_branch, tgt_reg, cfu_mret;
    logic cfu_ebreak, cfu_ecall, cfu_trap;
    logic instr_trap, tgt_trap;
    logic finish_now;

    // Decode ------------------------------
    assign fu_cfu       = s4_valid && s4_instr.fu[`WB_FU_CFU];
    assign pred_correct = fu_cfu && (s4_instr.uop == `WB_CFU_TAKEN ||
                                     s4_instr.uop == `WB_CFU_JALI);
    assign tgt_branch   = fu_cfu && s4_instr.uop == `WB_CFU_NOT_TAKEN;
    assign tgt_reg      = fu_cfu && s4_instr.uop == `WB_CFU_JALR;
    assign cfu_mret     = fu_cfu && s4_instr.uop == `WB_CFU_MRET;
    assign cfu_ebreak   = fu_cfu && s4_instr.uop == `WB_CFU_EBREAK;
    assign cfu_ecall    = fu_cfu && s4_instr.uop == `WB_CFU_ECALL;
    assign cfu_trap     = cfu_ebreak || cfu_ecall;
    assign instr_trap   = s4_valid && s4_instr.trap;   // Fault from earlier stage
    assign tgt_trap     = cfu_trap || instr_trap || lsu_trap;

    // Natural successor, size counts halfwords
    assign next_pc = pc + {{(`WB_XLEN-3){1'b0}}, s4_instr.size, 1'b0};

    // Request and target ------------------
    assign cf.req = !cf_done &&
                    (tgt_branch || tgt_reg || cfu_mret || tgt_trap);

    // Traps win over everything else
    assign cf.target = tgt_trap ? csr_mtvec :
                       ({`WB_XLEN{tgt_branch}} & next_pc        |
                        {`WB_XLEN{tgt_reg}}    & s4_instr.opr_a |
                        {`WB_XLEN{cfu_mret}}   & csr_mepc);

    assign finish_now = cf.req && cf_ack;
    assign cfu_busy   = fu_cfu && !(cf_done || finish_now) &&
                        (tgt_branch || tgt_reg || cfu_trap || cfu_mret);
    assign exec_mret  = cfu_mret && progress; // One pulse at retire

    // Request answered but the instruction is still waiting to leave
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else begin
            cf_done <= !progress && (cf_done || finish_now);
        end
    end

    // Program counter ---------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `WB_PC_RESET;
        end else if (pred_correct) begin
            pc <= s4_instr.opr_a;               // Target computed upstream
        end else if (finish_now) begin
            pc <= cf.target;
        end else if (progress) begin
            pc <= next_pc;
        end
    end

    // Trap report -------------------------
    assign trap.cpu   = cfu_trap || lsu_trap || instr_trap;
    assign trap.cause = (lsu_trap && !lsu_store_err) ? `WB_TRAP_LDACCESS :
                        lsu_store_err                ? `WB_TRAP_STACCESS :
                        cfu_ebreak                   ? `WB_TRAP_BREAKPT  :
                        cfu_ecall                    ? `WB_TRAP_ECALLM   :
                                                       s4_instr.opr_a[5:0];
    assign trap.pc    = pc;

endmodule

`default_nettype wire

/* src/wb_csr_access.sv */
// CSR request generation and once-only access tracking
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module wb_csr_access import wb_pkg::*; (
    input  wire            g_clk,
    input  wire            g_resetn,
    input  wire            s4_valid,
    input  wire wb_instr_t s4_instr,
    input  wire            progress,
    input  wire wb_word_t  csr_rdata,  // Same-cycle read answer
    output wb_csr_req_t    csr_req,
    output wb_gpr_write_t  csr_gpr
);

    logic fu_csr;
    logic csr_done;                    // Access already made for this instruction

    assign fu_csr = s4_valid && s4_instr.fu[`WB_FU_CSR];

    assign csr_req.en     = fu_csr && !csr_done;
    assign csr_req.wr     = fu_csr && s4_instr.uop[`WB_CSR_WRITE];
    assign csr_req.wr_set = fu_csr && s4_instr.uop[`WB_CSR_SET];
    assign csr_req.wr_clr = fu_csr && s4_instr.uop[`WB_CSR_CLEAR];
    assign csr_req.addr   = s4_instr.opr_b[11:0];
    assign csr_req.wdata  = s4_instr.opr_a;

    // Read result only valid in the access cycle
    assign csr_gpr.wen   = csr_req.en && s4_instr.uop[`WB_CSR_READ];
    assign csr_gpr.rd    = s4_instr.rd;
    assign csr_gpr.wdata = csr_rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !progress && (csr_done || csr_req.en);
        end
    end

endmodule

`default_nettype wire

/* src/wb_load_align.sv */
// Load response tracking, lane alignment, sign extension and bus errors
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module wb_load_align import wb_pkg::*; (
    input  wire               g_clk,
    input  wire               g_resetn,
    input  wire               s4_valid,
    input  wire wb_instr_t    s4_instr,
    input  wire               progress,
    input  wire wb_dmem_rsp_t dmem_rsp,
    output logic              dmem_ack,
    output wb_gpr_write_t     load_gpr,
    output logic              lsu_busy,
    output logic              lsu_trap,
    output logic              lsu_store_err
);

    logic       fu_lsu;
    logic       lsu_load, lsu_store, lsu_signed;
    logic       lsu_byte, lsu_half, lsu_word;
    logic [1:0] addr_lo;      // Byte offset in the word
    logic       strb_lane0;   // Lane 0 strobe from memory stage
    logic       rsp_seen;
    logic       rsp_take;     // Response accepted this cycle
    logic [7:0]  rdata_b0;
    logic [7:0]  rdata_b1;
    logic [15:0] rdata_h1;

    // Decode ------------------------------
    assign fu_lsu     = s4_valid && s4_instr.fu[`WB_FU_LSU];
    assign lsu_load   = fu_lsu && s4_instr.uop[`WB_LSU_LOAD];
    assign lsu_store  = fu_lsu && s4_instr.uop[`WB_LSU_STORE];
    assign lsu_signed = s4_instr.uop[`WB_LSU_SIGNED];
    assign lsu_byte   = s4_instr.uop[2:1] == `WB_LSU_BYTE;
    assign lsu_half   = s4_instr.uop[2:1] == `WB_LSU_HALF;
    assign lsu_word   = s4_instr.uop[2:1] == `WB_LSU_WORD;
    assign addr_lo    = s4_instr.opr_b[1:0];
    assign strb_lane0 = s4_instr.opr_a[0];

    // Response tracking -------------------
    assign dmem_ack = fu_lsu && !rsp_seen;          // Still expecting an answer
    assign rsp_take = dmem_rsp.recv && dmem_ack;
    assign lsu_busy = fu_lsu && !(rsp_seen || rsp_take);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
        end else begin
            rsp_seen <= !progress && (rsp_seen || rsp_take);
        end
    end

    // Lane alignment ----------------------
    always_comb begin
        rdata_b0 = 8'h00;
        if (strb_lane0) begin
            rdata_b0 = dmem_rsp.rdata[7:0];                     // Aligned access
        end else if (lsu_byte) begin
            rdata_b0 = dmem_rsp.rdata[{addr_lo, 3'b000} +: 8];
        end else if (lsu_half && addr_lo[1]) begin
            rdata_b0 = dmem_rsp.rdata[23:16];                   // Upper halfword
        end
    end

    always_comb begin
        rdata_b1 = 8'h00;
        if (lsu_byte && lsu_signed) begin
            rdata_b1 = {8{rdata_b0[7]}};
        end else if (lsu_half) begin
            rdata_b1 = addr_lo[1] ? dmem_rsp.rdata[31:24] : dmem_rsp.rdata[15:8];
        end else if (lsu_word) begin
            rdata_b1 = dmem_rsp.rdata[15:8];
        end
    end

    // Byte sign already copied into b1 above
    always_comb begin
        rdata_h1 = 16'h0000;
        if (lsu_word) begin
            rdata_h1 = dmem_rsp.rdata[31:16];
        end else if (lsu_signed && (lsu_byte || lsu_half)) begin
            rdata_h1 = {16{rdata_b1[7]}};
        end
    end

    // Results and errors ------------------
    assign lsu_trap      = rsp_take && dmem_rsp.error;
    assign lsu_store_err = lsu_trap && lsu_store;

    assign load_gpr.wen   = lsu_load && rsp_take && !dmem_rsp.error;
    assign load_gpr.rd    = s4_instr.rd;
    assign load_gpr.wdata = {rdata_h1, rdata_b1, rdata_b0};

endmodule

`default_nettype wire

/* src/wb_commit.sv */
// GPR write selection, forwarding, stage busy, LSU hold and trace packet
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module wb_commit import wb_pkg::*; (
    input  wire                s4_valid,
    input  wire wb_instr_t     s4_instr,
    input  wire wb_word_t      pc,
    input  wire wb_word_t      next_pc,
    input  wire wb_gpr_write_t csr_gpr,
    input  wire wb_gpr_write_t load_gpr,
    input  wire                cfu_busy,
    input  wire                lsu_busy,
    input  wire                cf_done,
    input  wire wb_cf_req_t    cf,
    input  wire                cf_ack,
    output logic               s4_busy,
    output logic               progress,
    output logic               hold_lsu_req,
    output wb_gpr_write_t      gpr,
    output wb_gpr_write_t      fwd,
    output logic               fwd_load,
    output logic               fwd_csr,
    output wb_trace_t          trace
);

    logic alu_wen, mul_wen;
    logic link_wen;                       // JALI or JALR link register

    assign alu_wen  = s4_valid && s4_instr.fu[`WB_FU_ALU];
    assign mul_wen  = s4_valid && s4_instr.fu[`WB_FU_MUL];
    assign link_wen = s4_valid && s4_instr.fu[`WB_FU_CFU] &&
                      (s4_instr.uop == `WB_CFU_JALI || s4_instr.uop == `WB_CFU_JALR);

    // Stage flow --------------------------
    assign s4_busy      = cfu_busy || lsu_busy || (cf.req && !cf_ack);
    assign progress     = s4_valid && !s4_busy;
    assign hold_lsu_req = cf.req || lsu_busy;   // No new memory requests yet

    // GPR writeback -----------------------
    assign gpr.wen   = !s4_instr.trap &&
                       (alu_wen || mul_wen || link_wen || csr_gpr.wen || load_gpr.wen);
    assign gpr.rd    = s4_instr.rd;
    assign gpr.wdata = {`WB_XLEN{alu_wen || mul_wen}} & s4_instr.opr_a |
                       {`WB_XLEN{link_wen}}           & next_pc        |
                       {`WB_XLEN{csr_gpr.wen}}        & csr_gpr.wdata  |
                       {`WB_XLEN{load_gpr.wen}}       & load_gpr.wdata;

    assign fwd      = gpr;
    assign fwd_load = s4_valid && s4_instr.fu[`WB_FU_LSU] && s4_instr.uop[`WB_LSU_LOAD];
    assign fwd_csr  = s4_valid && s4_instr.fu[`WB_FU_CSR];

    // Trace -------------------------------
    // One packet per instruction, at retire or in the ack cycle
    assign trace.valid = (|s4_instr.size) &&
                         (progress || (cf.req && cf_ack && !cf_done));
    assign trace.pc    = pc;
    assign trace.instr = s4_instr.instr;

endmodule

`default_nettype wire

/* src/wb_stage.sv */
// Writeback stage top level
`timescale 1ns/100ps
`default_nettype none

module wb_stage import wb_pkg::*; (
    input  wire               g_clk,
    input  wire               g_resetn,
    input  wire               s4_valid,
    input  wire wb_instr_t    s4_instr,
    output logic              s4_busy,
    output wb_cf_req_t        cf,
    input  wire               cf_ack,
    input  wire wb_dmem_rsp_t dmem_rsp,
    output logic              dmem_ack,
    output wb_csr_req_t       csr_req,
    input  wire wb_word_t     csr_rdata,
    input  wire wb_word_t     csr_mepc,
    input  wire wb_word_t     csr_mtvec,
    output wb_gpr_write_t     gpr,
    output wb_gpr_write_t     fwd,
    output logic              fwd_load,
    output logic              fwd_csr,
    output wb_trap_t          trap,
    output logic              exec_mret,
    output logic              hold_lsu_req,
    output wb_trace_t         trace
);

    wb_word_t      pc, next_pc;
    wb_gpr_write_t csr_gpr, load_gpr;   // Per-unit results
    logic          progress;
    logic          cfu_busy, cf_done;
    logic          lsu_busy, lsu_trap, lsu_store_err;

    wb_control_flow u_control_flow (
        .g_clk, .g_resetn, .s4_valid, .s4_instr, .progress, .cf_ack,
        .csr_mepc, .csr_mtvec, .lsu_trap, .lsu_store_err,
        .cf, .trap, .exec_mret, .cfu_busy, .pc, .next_pc, .cf_done
    );

    wb_csr_access u_csr_access (
        .g_clk, .g_resetn, .s4_valid, .s4_instr, .progress,
        .csr_rdata, .csr_req, .csr_gpr
    );

    wb_load_align u_load_align (
        .g_clk, .g_resetn, .s4_valid, .s4_instr, .progress, .dmem_rsp,
        .dmem_ack, .load_gpr, .lsu_busy, .lsu_trap, .lsu_store_err
    );

    wb_commit u_commit (
        .s4_valid, .s4_instr, .pc, .next_pc, .csr_gpr, .load_gpr,
        .cfu_busy, .lsu_busy, .cf_done, .cf, .cf_ack,
        .s4_busy, .progress, .hold_lsu_req, .gpr, .fwd, .fwd_load, .fwd_csr, .trace
    );

endmodule

`default_nettype wire

/* test/tb_wb_stage.sv */
// Writeback stage testbench with clock, reset, directed tests, compare tasks and timeout
`timescale 1ns/100ps
`default_nettype none

`include "wb_consts.svh"

module tb_wb_stage import wb_pkg::*; ();

    // About 70 instructions of at most 6 cycles each plus reset, with wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic          g_clk;
    logic          g_resetn;
    logic          s4_valid;
    wb_instr_t     s4_instr;
    logic          s4_busy;
    wb_cf_req_t    cf;
    logic          cf_ack;
    wb_dmem_rsp_t  dmem_rsp;
    logic          dmem_ack;
    wb_csr_req_t   csr_req;
    wb_word_t      csr_rdata;
    wb_word_t      csr_mepc;
    wb_word_t      csr_mtvec;
    wb_gpr_write_t gpr;
    wb_gpr_write_t fwd;
    logic          fwd_load;
    logic          fwd_csr;
    wb_trap_t      trap;
    logic          exec_mret;
    logic          hold_lsu_req;
    wb_trace_t     trace;

    integer   seed = 32'hc06ac614;
    wb_word_t exp_pc;               // Reference PC of the instruction in the stage
    int       mismatch_count = 0;
    int       fail_count = 0;
    int       cycle_count = 0;

    wb_stage dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;  // 8 ns period
    end

    // Timeout ----------------------
    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            fail_count = fail_count + 1;
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
            $display("Test failed");
            $finish;
        end
    end

    // Compare tasks ----------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Data and rd only matter when a write is expected
    task automatic check_gpr(input string name, input wb_gpr_write_t got,
                             input wb_gpr_write_t exp);
        if (got.wen !== exp.wen || (exp.wen && got !== exp)) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cf(input string name, input wb_cf_req_t got, input wb_cf_req_t exp);
        if (got.req !== exp.req || (exp.req && got !== exp)) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_trap(input string name, input wb_trap_t got, input wb_trap_t exp);
        if (got.cpu !== exp.cpu || (exp.cpu && got !== exp)) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_csr(input string name, input wb_csr_req_t got, input wb_csr_req_t exp);
        if (got.en !== exp.en || (exp.en && got !== exp)) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_trace(input string name, input wb_trace_t got, input wb_trace_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Stimulus helpers -------------
    task automatic issue(input wb_instr_t ins);
        @(posedge g_clk);
        s4_valid <= 1'b1;
        s4_instr <= ins;
        cf_ack   <= 1'b0;
        dmem_rsp <= '0;
    endtask

    task automatic check_idle();
        check_gpr("gpr", gpr, '0);
        check_cf("cf", cf, '0);
        check_csr("csr_req", csr_req, '0);
        check_trace("trace", trace, '0);
        check_bit("exec_mret", exec_mret, 1'b0);
        check_bit("dmem_ack", dmem_ack, 1'b0);
        check_bit("hold_lsu_req", hold_lsu_req, 1'b0);
        check_bit("s4_busy", s4_busy, 1'b0);
    endtask

    task automatic release_stage();
        @(posedge g_clk);                       // Retire edge
        s4_valid <= 1'b0;
        s4_instr <= '0;
        cf_ack   <= 1'b0;
        dmem_rsp <= '0;
        @(negedge g_clk);
        check_idle();                           // Nothing left active once empty
    endtask

    // Byte or halfword lane at the offset, then zero or sign extension
    function automatic wb_word_t load_value(input logic [1:0] sz, input logic sgn,
                                            input logic [1:0] off, input wb_word_t rdata);
        wb_word_t shifted;
        shifted = rdata >> (8 * off);
        case (sz)
            `WB_LSU_BYTE: load_value = sgn ? {{24{shifted[7]}}, shifted[7:0]} :
                                             {24'd0, shifted[7:0]};
            `WB_LSU_HALF: load_value = sgn ? {{16{shifted[15]}}, shifted[15:0]} :
                                             {16'd0, shifted[15:0]};
            default:      load_value = rdata;
        endcase
    endfunction

    // ALU and MUL ------------------
    task automatic test_alu_mul(input int count);
        wb_instr_t     ins;
        wb_gpr_write_t exp_gpr;
        for (int i = 0; i < count; i++) begin
            ins       = '0;
            ins.fu    = (i % 2 == 0) ? (5'b1 << `WB_FU_ALU) : (5'b1 << `WB_FU_MUL);
            ins.rd    = $random(seed);
            ins.opr_a = $random(seed);
            ins.size  = (i % 3 == 0) ? 2'd1 : 2'd2;   // Compressed now and then
            ins.instr = $random(seed);
            exp_gpr   = {1'b1, ins.rd, ins.opr_a};
            issue(ins);
            @(negedge g_clk);
            check_bit("s4_busy", s4_busy, 1'b0);
            check_gpr("gpr", gpr, exp_gpr);
            check_gpr("fwd", fwd, exp_gpr);
            check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
            release_stage();
            exp_pc = exp_pc + {ins.size, 1'b0};
        end
    endtask

    // Upstream trap on an ALU op, fetch acks at once
    task automatic test_alu_trap();
        wb_instr_t ins;
        ins       = '0;
        ins.fu    = 5'b1 << `WB_FU_ALU;
        ins.trap  = 1'b1;
        ins.rd    = $random(seed);
        ins.opr_a = $random(seed);
        ins.size  = 2'd2;
        ins.instr = $random(seed);
        issue(ins);
        cf_ack <= 1'b1;
        @(negedge g_clk);
        check_bit("s4_busy", s4_busy, 1'b0);
        check_gpr("gpr", gpr, '0);              // Write suppressed
        check_cf("cf", cf, {1'b1, csr_mtvec});
        check_trap("trap", trap, {1'b1, ins.opr_a[5:0], exp_pc});
        check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
        release_stage();
        exp_pc = csr_mtvec;
    endtask

    // Loads and stores -------------
    task automatic run_lsu(input logic [1:0] sz, input logic sgn, input logic [1:0] off,
                           input logic err, input logic store);
        wb_instr_t     ins;
        wb_word_t      rdata;
        wb_gpr_write_t exp_gpr;
        wb_trap_t      exp_trap;
        wb_cf_req_t    exp_cf;
        int            delay;
        ins       = '0;
        ins.fu    = 5'b1 << `WB_FU_LSU;
        ins.uop   = {store, !store, sz, sgn};
        ins.rd    = $random(seed);
        ins.opr_a = {31'd0, off == 2'd0};               // Lane 0 strobe
        ins.opr_b = ({$random(seed)} & ~32'h3) | off;
        ins.size  = 2'd2;
        ins.instr = $random(seed);
        rdata     = $random(seed);
        delay     = $random(seed) & 3;
        exp_gpr   = '0;
        exp_trap  = '0;
        exp_cf    = '0;
        if (!store && !err) begin
            exp_gpr = {1'b1, ins.rd, load_value(sz, sgn, off, rdata)};
        end
        if (err) begin
            exp_trap = {1'b1, store ? `WB_TRAP_STACCESS : `WB_TRAP_LDACCESS, exp_pc};
            exp_cf   = {1'b1, csr_mtvec};
        end
        issue(ins);
        for (int i = 0; i < delay; i++) begin
            @(negedge g_clk);
            check_bit("s4_busy", s4_busy, 1'b1);
            check_bit("dmem_ack", dmem_ack, 1'b1);
            check_bit("hold_lsu_req", hold_lsu_req, 1'b1);
            check_gpr("gpr", gpr, '0);
            @(posedge g_clk);
        end
        dmem_rsp <= {1'b1, err, rdata};
        cf_ack   <= err;                                // Redirect taken with the error
        @(negedge g_clk);
        check_bit("s4_busy", s4_busy, 1'b0);
        check_bit("dmem_ack", dmem_ack, 1'b1);
        check_bit("fwd_load", fwd_load, !store);
        check_gpr("gpr", gpr, exp_gpr);
        check_trap("trap", trap, exp_trap);
        check_cf("cf", cf, exp_cf);
        check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
        release_stage();
        exp_pc = err ? csr_mtvec : exp_pc + 32'd4;
    endtask

    task automatic test_loads();
        for (int s = 1; s <= 3; s++) begin
            for (int g = 0; g < 2; g++) begin
                for (int o = 0; o < 4; o++) begin
                    if (o % (1 << (s - 1)) == 0) begin  // Naturally aligned only
                        run_lsu(s, g, o, 1'b0, 1'b0);
                    end
                end
            end
        end
        run_lsu(`WB_LSU_WORD, 1'b0, 2'd0, 1'b1, 1'b0);  // Load bus error
        run_lsu(`WB_LSU_HALF, 1'b1, 2'd2, 1'b1, 1'b0);
        run_lsu(`WB_LSU_WORD, 1'b0, 2'd0, 1'b0, 1'b1);  // Clean store
        run_lsu(`WB_LSU_WORD, 1'b0, 2'd0, 1'b1, 1'b1);  // Store bus error
    endtask

    // CSR access -------------------
    task automatic run_csr(input logic [3:0] ops);      // Read, write, set, clear
        wb_instr_t     ins;
        wb_word_t      rdata;
        wb_gpr_write_t exp_gpr;
        ins       = '0;
        ins.fu    = 5'b1 << `WB_FU_CSR;
        ins.uop   = {ops, 1'b0};
        ins.rd    = $random(seed);
        ins.opr_a = $random(seed);
        ins.opr_b = $random(seed);
        ins.size  = 2'd2;
        ins.instr = $random(seed);
        rdata     = $random(seed);
        exp_gpr   = '0;
        if (ops[3]) begin
            exp_gpr = {1'b1, ins.rd, rdata};
        end
        issue(ins);
        csr_rdata <= rdata;
        @(negedge g_clk);
        check_csr("csr_req", csr_req, {1'b1, ops[2:0], ins.opr_b[11:0], ins.opr_a});
        check_gpr("gpr", gpr, exp_gpr);
        check_bit("fwd_csr", fwd_csr, 1'b1);
        check_bit("s4_busy", s4_busy, 1'b0);
        check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
        release_stage();
        exp_pc = exp_pc + 32'd4;
    endtask

    // CSR read held in the stage by an upstream trap until fetch acks
    task automatic test_csr_stall();
        wb_instr_t ins;
        ins       = '0;
        ins.fu    = 5'b1 << `WB_FU_CSR;
        ins.uop   = 5'b1 << `WB_CSR_READ;
        ins.trap  = 1'b1;
        ins.rd    = $random(seed);
        ins.opr_a = $random(seed);
        ins.opr_b = $random(seed);
        ins.size  = 2'd2;
        ins.instr = $random(seed);
        issue(ins);
        @(negedge g_clk);
        check_csr("csr_req", csr_req, {1'b1, 3'b000, ins.opr_b[11:0], ins.opr_a});
        check_gpr("gpr", gpr, '0);                      // Read result dropped by the trap
        check_bit("s4_busy", s4_busy, 1'b1);
        for (int i = 0; i < 2; i++) begin
            @(negedge g_clk);
            check_csr("csr_req", csr_req, '0);          // Access made once only
            check_cf("cf", cf, {1'b1, csr_mtvec});
            check_bit("s4_busy", s4_busy, 1'b1);
        end
        @(posedge g_clk);
        cf_ack <= 1'b1;
        @(negedge g_clk);
        check_csr("csr_req", csr_req, '0);
        check_bit("s4_busy", s4_busy, 1'b0);
        check_trap("trap", trap, {1'b1, ins.opr_a[5:0], exp_pc});
        check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
        release_stage();
        exp_pc = csr_mtvec;
    endtask

    // Control flow -----------------
    task automatic run_cf(input logic [4:0] op);
        wb_instr_t     ins;
        wb_cf_req_t    exp_cf;
        wb_gpr_write_t exp_gpr;
        wb_trap_t      exp_trap;
        int            delay;
        ins       = '0;
        ins.fu    = 5'b1 << `WB_FU_CFU;
        ins.uop   = op;
        ins.rd    = $random(seed);
        ins.opr_a = {$random(seed)} & ~32'h1;
        ins.size  = 2'd2;
        ins.instr = $random(seed);
        exp_gpr   = '0;
        exp_trap  = '0;
        case (op)
            `WB_CFU_NOT_TAKEN: exp_cf = {1'b1, exp_pc + 32'd4};
            `WB_CFU_JALR: begin
                exp_cf  = {1'b1, ins.opr_a};
                exp_gpr = {1'b1, ins.rd, exp_pc + 32'd4};   // Link address
            end
            `WB_CFU_MRET: exp_cf = {1'b1, csr_mepc};
            `WB_CFU_EBREAK: begin
                exp_cf   = {1'b1, csr_mtvec};
                exp_trap = {1'b1, `WB_TRAP_BREAKPT, exp_pc};
            end
            default: begin
                exp_cf   = {1'b1, csr_mtvec};
                exp_trap = {1'b1, `WB_TRAP_ECALLM, exp_pc};
            end
        endcase
        delay = $random(seed) & 3;
        issue(ins);
        for (int i = 0; i < delay; i++) begin
            @(negedge g_clk);
            check_cf("cf", cf, exp_cf);                 // Held stable while unanswered
            check_bit("s4_busy", s4_busy, 1'b1);
            check_bit("hold_lsu_req", hold_lsu_req, 1'b1);
            check_bit("exec_mret", exec_mret, 1'b0);
            check_trace("trace", trace, '0);
            @(posedge g_clk);
        end
        cf_ack <= 1'b1;
        @(negedge g_clk);
        check_cf("cf", cf, exp_cf);
        check_bit("s4_busy", s4_busy, 1'b0);
        check_gpr("gpr", gpr, exp_gpr);
        check_trap("trap", trap, exp_trap);
        check_bit("exec_mret", exec_mret, op == `WB_CFU_MRET);
        check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
        release_stage();
        exp_pc = exp_cf.target;
    endtask

    // TAKEN and JALI, already redirected upstream
    task automatic run_predicted(input logic [4:0] op);
        wb_instr_t     ins;
        wb_gpr_write_t exp_gpr;
        ins       = '0;
        ins.fu    = 5'b1 << `WB_FU_CFU;
        ins.uop   = op;
        ins.rd    = $random(seed);
        ins.opr_a = {$random(seed)} & ~32'h1;
        ins.size  = 2'd2;
        ins.instr = $random(seed);
        exp_gpr   = '0;
        if (op == `WB_CFU_JALI) begin
            exp_gpr = {1'b1, ins.rd, exp_pc + 32'd4};
        end
        issue(ins);
        @(negedge g_clk);
        check_cf("cf", cf, '0);
        check_bit("s4_busy", s4_busy, 1'b0);
        check_gpr("gpr", gpr, exp_gpr);
        check_trace("trace", trace, {1'b1, exp_pc, ins.instr});
        release_stage();
        exp_pc = ins.opr_a;
    endtask

    // Main sequence ----------------
    initial begin
        g_resetn  = 1'b0;
        s4_valid  = 1'b0;
        s4_instr  = '0;
        cf_ack    = 1'b0;
        dmem_rsp  = '0;
        csr_rdata = '0;
        csr_mepc  = {$random(seed)} & ~32'h3;
        csr_mtvec = {$random(seed)} & ~32'h3;
        exp_pc    = `WB_PC_RESET;
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_idle();

        test_alu_mul(12);
        test_alu_trap();
        test_loads();
        for (int k = 0; k < 16; k++) begin
            run_csr(k);
        end
        test_csr_stall();
        // Trace PC follows every redirect through the model
        for (int r = 0; r < 3; r++) begin
            run_predicted(`WB_CFU_TAKEN);
            run_cf(`WB_CFU_NOT_TAKEN);
            run_cf(`WB_CFU_JALR);
            run_predicted(`WB_CFU_JALI);
            run_cf(`WB_CFU_MRET);
            run_cf(`WB_CFU_ECALL);
            run_cf(`WB_CFU_EBREAK);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/wb_pkg.sv
src/wb_control_flow.sv
src/wb_csr_access.sv
src/wb_load_align.sv
src/wb_commit.sv
src/wb_stage.sv
test/tb_wb_stage.sv

/* Bender.yml */
package:
  name: wb_stage

export_include_dirs:
  - src

sources:
  - files:
      - src/wb_pkg.sv
      - src/wb_control_flow.sv
      - src/wb_csr_access.sv
      - src/wb_load_align.sv
      - src/wb_commit.sv
      - src/wb_stage.sv
  - target: test
    files:
      - test/tb_wb_stage.sv
